//--- src/shq_pkg.sv
package shq_pkg;

  // Field widths shared by every block
  localparam int data_w    = 16;
  localparam int fifo_id_w = 2;
  localparam int addr_w    = 4;
  localparam int count_w   = 5;

  // One item from the sender
  typedef struct packed {
    logic [fifo_id_w-1:0] fifo_id;
    logic [data_w-1:0]    data;
  } push_req_t;

  // Entry handed out by the free list for a push
  typedef struct packed {
    logic                 valid;
    logic [fifo_id_w-1:0] fifo_id;
    logic [addr_w-1:0]    entry;
  } alloc_t;

  // Link table update, entry now points at next
  typedef struct packed {
    logic              valid;
    logic [addr_w-1:0] entry;
    logic [addr_w-1:0] next;
  } link_wr_t;

  // Entry released by a pop, with its successor in the list
  typedef struct packed {
    logic                 valid;
    logic [fifo_id_w-1:0] fifo_id;
    logic [addr_w-1:0]    entry;
    logic [addr_w-1:0]    next;
  } dealloc_t;

endpackage

//--- src/shq_credit_receiver.sv
`timescale 1ns/1ns

module shq_credit_receiver import shq_pkg::*; #(
  parameter int depth = 12
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               push_credit_stall,
  output logic               push_credit,
  input  logic               push_valid,
  input  push_req_t          push_req,
  input  dealloc_t           dealloc,
  output logic               alloc_push_valid,
  output push_req_t          alloc_push_req,
  output logic [count_w-1:0] credit_count
);

  logic rst_d;
  logic issue;

  // Held off for one cycle after reset, until the free list is ready
  always_ff @(posedge clk) begin
    rst_d <= rst;
  end

  assign issue       = (credit_count != '0) && !push_credit_stall && !rst_d;
  assign push_credit = issue;

  // Credits not yet handed to the sender
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_count <= count_w'(depth);
    end else begin
      case ({issue, dealloc.valid})
        2'b10:   credit_count <= credit_count - 1'b1;
        2'b01:   credit_count <= credit_count + 1'b1;
        default: credit_count <= credit_count;
      endcase
    end
  end

  // Registered push stage toward the push control
  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_push_valid <= 1'b0;
    end else begin
      alloc_push_valid <= push_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (push_valid) begin
      alloc_push_req <= push_req;
    end
  end

endmodule

//--- src/shq_push_ctrl.sv
`timescale 1ns/1ns

module shq_push_ctrl import shq_pkg::*; #(
  parameter int depth = 12
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              push_valid,
  input  push_req_t         push_req,
  input  dealloc_t          dealloc,
  output alloc_t            alloc,
  output logic              push_full,
  output logic              data_wr_valid,
  output logic [addr_w-1:0] data_wr_addr,
  output logic [data_w-1:0] data_wr_data
);

  // Free list kept as a circular queue of entry numbers
  logic [addr_w-1:0]  fl_mem [depth];
  logic [addr_w-1:0]  rd_ptr;
  logic [addr_w-1:0]  wr_ptr;
  logic [count_w-1:0] fl_count;

  assign push_full = (fl_count == '0);

  assign alloc.valid   = push_valid;
  assign alloc.fifo_id = push_req.fifo_id;
  assign alloc.entry   = fl_mem[rd_ptr];

  // Data goes straight into the entry just taken
  assign data_wr_valid = push_valid;
  assign data_wr_addr  = fl_mem[rd_ptr];
  assign data_wr_data  = push_req.data;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      fl_count <= count_w'(depth);
      for (int i = 0; i < depth; i++) begin
        fl_mem[i] <= addr_w'(i);
      end
    end else begin
      if (push_valid) begin
        rd_ptr <= (rd_ptr == addr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (dealloc.valid) begin
        fl_mem[wr_ptr] <= dealloc.entry;
        wr_ptr         <= (wr_ptr == addr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      case ({push_valid, dealloc.valid})
        2'b10:   fl_count <= fl_count - 1'b1;
        2'b01:   fl_count <= fl_count + 1'b1;
        default: fl_count <= fl_count;
      endcase
    end
  end

endmodule

//--- src/shq_list_ctrl.sv
`timescale 1ns/1ns

module shq_list_ctrl import shq_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [fifo_id_w-1:0] fifo_id,
  input  alloc_t               alloc,
  input  dealloc_t             dealloc,
  output link_wr_t             link_wr,
  output logic [addr_w-1:0]    head,
  output logic                 not_empty
);

  logic [addr_w-1:0]  tail;
  logic [count_w-1:0] count;
  logic               a_hit;
  logic               d_hit;

  assign a_hit     = alloc.valid && (alloc.fifo_id == fifo_id);
  assign d_hit     = dealloc.valid && (dealloc.fifo_id == fifo_id);
  assign not_empty = (count != '0);

  // Link the old tail to the new entry, fields stay zero when idle
  // so the top level can OR all lists together
  always_comb begin
    link_wr = '0;
    if (a_hit && not_empty) begin
      link_wr.valid = 1'b1;
      link_wr.entry = tail;
      link_wr.next  = alloc.entry;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (a_hit) begin
        tail <= alloc.entry;
      end
      // Last entry leaving while a new one arrives, the link read was stale
      if (a_hit && (!not_empty || (d_hit && count == count_w'(1)))) begin
        head <= alloc.entry;
      end else if (d_hit) begin
        head <= dealloc.next;
      end
      case ({a_hit, d_hit})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/shq_entry_store.sv
`timescale 1ns/1ns

module shq_entry_store import shq_pkg::*; (
  input  logic              clk,
  input  logic              data_wr_valid,
  input  logic [addr_w-1:0] data_wr_addr,
  input  logic [data_w-1:0] data_wr_data,
  input  link_wr_t          link_wr,
  input  logic [addr_w-1:0] data_rd_addr,
  output logic [data_w-1:0] data_rd_data,
  input  logic [addr_w-1:0] link_rd_addr,
  output logic [addr_w-1:0] link_rd_data
);

  localparam int num_entries = 2 ** addr_w;

  logic [data_w-1:0] data_mem [num_entries];
  logic [addr_w-1:0] link_mem [num_entries];

  always_ff @(posedge clk) begin
    if (data_wr_valid) begin
      data_mem[data_wr_addr] <= data_wr_data;
    end
  end

  // Successor pointer of each entry
  always_ff @(posedge clk) begin
    if (link_wr.valid) begin
      link_mem[link_wr.entry] <= link_wr.next;
    end
  end

  assign data_rd_data = data_mem[data_rd_addr];
  assign link_rd_data = link_mem[link_rd_addr];

endmodule

//--- src/shq_pop_ctrl.sv
`timescale 1ns/1ns

module shq_pop_ctrl import shq_pkg::*; #(
  parameter int num_fifos = 4
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [num_fifos-1:0][addr_w-1:0] heads,
  input  logic [num_fifos-1:0]           not_empty,
  output logic [addr_w-1:0]              data_rd_addr,
  input  logic [data_w-1:0]              data_rd_data,
  output logic [addr_w-1:0]              link_rd_addr,
  input  logic [addr_w-1:0]              link_rd_data,
  output logic                           pop_valid,
  input  logic                           pop_ready,
  output logic [data_w-1:0]              pop_data,
  output logic [fifo_id_w-1:0]           pop_fifo_id,
  output dealloc_t                       dealloc
);

  logic [fifo_id_w-1:0] last_q;
  logic [fifo_id_w-1:0] lock_id_q;
  logic                 lock_q;
  logic [fifo_id_w-1:0] rr_id;
  logic [fifo_id_w-1:0] sel;
  logic                 fire;

  // First non-empty list after the one served last
  always_comb begin
    int  idx;
    logic found;
    rr_id = '0;
    found = 1'b0;
    for (int k = 1; k <= num_fifos; k++) begin
      idx = (int'(last_q) + k) % num_fifos;
      if (!found && not_empty[idx]) begin
        found = 1'b1;
        rr_id = fifo_id_w'(idx);
      end
    end
  end

  // Hold the choice while the consumer stalls
  assign sel       = lock_q ? lock_id_q : rr_id;
  assign pop_valid = |not_empty;
  assign fire      = pop_valid && pop_ready;

  assign data_rd_addr = heads[sel];
  assign link_rd_addr = heads[sel];
  assign pop_data     = data_rd_data;
  assign pop_fifo_id  = sel;

  assign dealloc.valid   = fire;
  assign dealloc.fifo_id = sel;
  assign dealloc.entry   = heads[sel];
  assign dealloc.next    = link_rd_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_q    <= fifo_id_w'(num_fifos - 1);
      lock_q    <= 1'b0;
      lock_id_q <= '0;
    end else begin
      lock_q    <= pop_valid && !pop_ready;
      lock_id_q <= sel;
      if (fire) begin
        last_q <= sel;
      end
    end
  end

endmodule

//--- src/shq_top.sv
`timescale 1ns/1ns

module shq_top import shq_pkg::*; #(
  parameter int num_fifos = 4,
  parameter int depth     = 12
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 push_credit_stall,
  output logic                 push_credit,
  input  logic                 push_valid,
  input  push_req_t            push_req,
  output logic                 push_full,
  output logic [count_w-1:0]   credit_count,
  output logic                 pop_valid,
  input  logic                 pop_ready,
  output logic [data_w-1:0]    pop_data,
  output logic [fifo_id_w-1:0] pop_fifo_id
);

  logic                            alloc_push_valid;
  push_req_t                       alloc_push_req;
  alloc_t                          alloc;
  dealloc_t                        dealloc;
  link_wr_t                        link_wrs [num_fifos];
  link_wr_t                        link_wr;
  logic [num_fifos-1:0][addr_w-1:0] heads;
  logic [num_fifos-1:0]            not_empty;
  logic                            data_wr_valid;
  logic [addr_w-1:0]               data_wr_addr;
  logic [data_w-1:0]               data_wr_data;
  logic [addr_w-1:0]               data_rd_addr;
  logic [data_w-1:0]               data_rd_data;
  logic [addr_w-1:0]               link_rd_addr;
  logic [addr_w-1:0]               link_rd_data;

  shq_credit_receiver #(.depth(depth)) i_credit_receiver (
    .clk, .rst, .push_credit_stall, .push_credit, .push_valid, .push_req,
    .dealloc, .alloc_push_valid, .alloc_push_req, .credit_count
  );

  shq_push_ctrl #(.depth(depth)) i_push_ctrl (
    .clk, .rst, .push_valid(alloc_push_valid), .push_req(alloc_push_req),
    .dealloc, .alloc, .push_full, .data_wr_valid, .data_wr_addr, .data_wr_data
  );

  for (genvar i = 0; i < num_fifos; i++) begin : gen_list
    shq_list_ctrl i_list_ctrl (
      .clk, .rst, .fifo_id(fifo_id_w'(i)), .alloc, .dealloc,
      .link_wr(link_wrs[i]), .head(heads[i]), .not_empty(not_empty[i])
    );
  end

  // Only one list appends per cycle, idle lists drive zero
  always_comb begin
    link_wr = '0;
    for (int i = 0; i < num_fifos; i++) begin
      link_wr = link_wr_t'(link_wr | link_wrs[i]);
    end
  end

  shq_entry_store i_entry_store (
    .clk, .data_wr_valid, .data_wr_addr, .data_wr_data, .link_wr,
    .data_rd_addr, .data_rd_data, .link_rd_addr, .link_rd_data
  );

  shq_pop_ctrl #(.num_fifos(num_fifos)) i_pop_ctrl (
    .clk, .rst, .heads, .not_empty, .data_rd_addr, .data_rd_data,
    .link_rd_addr, .link_rd_data, .pop_valid, .pop_ready, .pop_data,
    .pop_fifo_id, .dealloc
  );

endmodule

//--- testbench/shq_asserts.sv
`timescale 1ns/1ns

module shq_asserts import shq_pkg::*; (
  input logic                 clk,
  input logic                 rst,
  input logic                 push_credit,
  input logic                 push_valid,
  input logic                 alloc_push_valid,
  input logic                 push_full,
  input logic                 pop_valid,
  input logic                 pop_ready,
  input logic [data_w-1:0]    pop_data,
  input logic [fifo_id_w-1:0] pop_fifo_id
);

  // Credits the sender holds before this cycle's grant
  logic [count_w:0] held;

  always_ff @(posedge clk) begin
    if (rst) begin
      held <= '0;
    end else begin
      held <= held + (count_w+1)'(push_credit) - (count_w+1)'(push_valid);
    end
  end

  push_has_credit: assert property (@(posedge clk) disable iff (rst)
    push_valid |-> held != '0)
    else $error("push without a held credit");

  no_push_when_full: assert property (@(posedge clk) disable iff (rst)
    !(push_full && alloc_push_valid))
    else $error("push reached the free list while it was empty");

  pop_stable: assert property (@(posedge clk) disable iff (rst)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data) && $stable(pop_fifo_id))
    else $error("pop outputs changed under back-pressure");

endmodule

bind shq_top shq_asserts i_asserts (
  .clk, .rst, .push_credit, .push_valid, .alloc_push_valid, .push_full,
  .pop_valid, .pop_ready, .pop_data, .pop_fifo_id
);

//--- testbench/shq_tb.sv
`timescale 1ns/1ns

module shq_tb import shq_pkg::*; ();

  localparam int num_fifos = 4;
  localparam int depth     = 12;

  logic                 clk;
  logic                 rst;
  logic                 push_credit_stall;
  logic                 push_credit;
  logic                 push_valid;
  push_req_t            push_req;
  logic                 push_full;
  logic [count_w-1:0]   credit_count;
  logic                 pop_valid;
  logic                 pop_ready;
  logic [data_w-1:0]    pop_data;
  logic [fifo_id_w-1:0] pop_fifo_id;

  // Command table loaded from the data file
  string       cmds [$];
  int          arg_a [$];
  int          arg_b [$];
  logic [15:0] model_q [num_fifos][$];
  int          stamp_q [num_fifos][$];
  int          cycle = 0;
  int          limit = 100000;
  int          credits_held = 0;
  int          credits_rcvd = 0;
  int          pops = 0;
  int          last_id = 0;
  bit          had_last = 0;
  bit          offering = 0;
  int          offer_start = 0;
  bit          ready_mode = 1;
  logic [31:0] rng = 32'he860;

  shq_top #(.num_fifos(num_fifos), .depth(depth)) i_dut (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle++;
    if (cycle > limit) begin
      abort("Timeout, the run took longer than its cycle budget");
    end
  end

  task automatic abort(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input int expected, input int actual);
    if (expected != actual) begin
      abort($sformatf("Mismatch %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic take_pop();
    int id;
    int start;
    id = pop_fifo_id;
    if (model_q[id].size() == 0) begin
      abort($sformatf("Pop from FIFO %0d while its model queue is empty", id));
    end
    check("pop_data", model_q[id][0], pop_data);
    // Repeat is only allowed when no other FIFO was visible at offer time
    start = offering ? offer_start : cycle;
    if (had_last && id == last_id) begin
      for (int j = 0; j < num_fifos; j++) begin
        if (j != id && model_q[j].size() > 0 && stamp_q[j][0] + 2 <= start) begin
          check("round_robin", j, id);
        end
      end
    end
    void'(model_q[id].pop_front());
    void'(stamp_q[id].pop_front());
    offering = 0;
    last_id  = id;
    had_last = 1;
    pops++;
  endtask

  // Sample before the edge, then drive defaults 1 ns after it
  task automatic step();
    @(negedge clk);
    if (push_credit) begin
      credits_held++;
      credits_rcvd++;
    end
    if (push_credit_stall) begin
      check("stall_credit", 0, push_credit);
    end
    if (pop_valid && !pop_ready && !offering) begin
      offering    = 1;
      offer_start = cycle;
    end
    if (pop_valid && pop_ready) begin
      take_pop();
    end
    @(posedge clk);
    #1;
    push_valid = 0;
    rng        = xorshift(rng);
    pop_ready  = ready_mode && (rng[1:0] != 2'b00);
  endtask

  function automatic bit all_empty();
    for (int j = 0; j < num_fifos; j++) begin
      if (model_q[j].size() != 0) begin
        return 0;
      end
    end
    return 1;
  endfunction

  task automatic load_commands();
    int    fd;
    int    a;
    int    b;
    string cmd;
    reg [8*128-1:0] line;
    fd = $fopen("testbench/shq_testdata.txt", "r");
    if (fd == 0) begin
      abort("Could not open testbench/shq_testdata.txt");
    end
    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd == "#") begin
        void'($fgets(line, fd));
      end else begin
        void'($fscanf(fd, "%h %h", a, b));
        cmds.push_back(cmd);
        arg_a.push_back(a);
        arg_b.push_back(b);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    clk = 0;
    rst = 1;
    push_credit_stall = 0;
    push_valid = 0;
    push_req = '0;
    pop_ready = 0;
    load_commands();
    limit = 40 * cmds.size() + 200;
    repeat (3) @(posedge clk);
    #1;
    rst = 0;
    foreach (cmds[i]) begin
      case (cmds[i])
        "P": begin
          do step(); while (credits_held == 0);
          push_valid       = 1;
          push_req.fifo_id = fifo_id_w'(arg_a[i]);
          push_req.data    = data_w'(arg_b[i]);
          credits_held--;
          model_q[arg_a[i]].push_back(data_w'(arg_b[i]));
          stamp_q[arg_a[i]].push_back(cycle);
        end
        "S": begin
          repeat (arg_a[i]) step();
          push_credit_stall = 1;
          repeat (arg_b[i]) step();
          push_credit_stall = 0;
        end
        "H": ready_mode = arg_a[i][0];
        "F": begin
          repeat (4) step();
          check("push_full", arg_a[i], push_full);
        end
        "C": begin
          while (!all_empty()) step();
          repeat (20) step();
          check("credit_count", arg_a[i], credit_count);
          check("credit_total", pops + depth, credits_rcvd);
          check("pop_valid_idle", 0, pop_valid);
        end
        default: abort($sformatf("Unknown command %s in the test data", cmds[i]));
      endcase
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- testbench/shq_testdata.txt
# Columns: command, then two hex arguments
# P fifo data / S start len / H ready_on x / F push_full x / C credit_count x
S 0 6
C 0 0
H 0 0
P 0 a000
P 0 a001
P 0 a002
P 0 a003
P 0 a004
P 0 a005
P 0 a006
P 0 a007
P 0 a008
P 0 a009
P 0 a00a
P 0 a00b
F 1 0
H 1 0
C 0 0
P 1 b100
P 2 b200
P 3 b300
P 1 b101
S 3 5
P 0 b000
P 2 b201
P 3 b301
P 1 b102
C 0 0

//--- files.f
src/shq_pkg.sv
src/shq_credit_receiver.sv
src/shq_push_ctrl.sv
src/shq_list_ctrl.sv
src/shq_entry_store.sv
src/shq_pop_ctrl.sv
src/shq_top.sv
testbench/shq_asserts.sv
testbench/shq_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module shq_tb -o shq_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/shq_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1
